// ==== Bender.yml ====
package:
  name: psx_loader

sources:
  # Design
  - rtl/psx_loader_pkg.sv
  - rtl/download_decode.sv
  - rtl/halfword_gather.sv
  - rtl/ram_loader.sv
  - rtl/psx_loader_top.sv

  # Testbench
  - target: test
    files:
      - verif/loader_checker.sv
      - verif/tb_top.sv

// ==== list.f ====
rtl/psx_loader_pkg.sv
rtl/download_decode.sv
rtl/halfword_gather.sv
rtl/ram_loader.sv
rtl/psx_loader_top.sv
verif/loader_checker.sv
verif/tb_top.sv

// ==== rtl/download_decode.sv ====
// Download kind decoder
// Registers which file type the host is sending and derives the
// system reset request and the executable-end and cheat-start strobes
`default_nettype none

module download_decode (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	output psx_loader_pkg::dl_kind_t kind,
	output logic                     sys_reset_req,
	output logic                     exe_load,
	output logic                     cheat_clear
);

	psx_loader_pkg::dl_kind_t kind_next;
	// Kind one cycle back, for edge detection
	psx_loader_pkg::dl_kind_t kind_prev;

	// ========================================
	// Index decode
	// ========================================

	always_comb begin
		kind_next = psx_loader_pkg::kind_none;
		if (ioctl_download) begin
			case (ioctl_index)
				psx_loader_pkg::idx_bios: kind_next = psx_loader_pkg::kind_bios;
				psx_loader_pkg::idx_exe:  kind_next = psx_loader_pkg::kind_exe;
				psx_loader_pkg::idx_code: kind_next = psx_loader_pkg::kind_code;
				// Other file types are not handled here
				default:                  kind_next = psx_loader_pkg::kind_none;
			endcase
		end
	end

	// ========================================
	// Kind register and strobes
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			kind        <= psx_loader_pkg::kind_none;
			kind_prev   <= psx_loader_pkg::kind_none;
			exe_load    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			kind      <= kind_next;
			kind_prev <= kind;

			// Executable finished, start it
			exe_load <= (kind_prev == psx_loader_pkg::kind_exe) &&
				(kind != psx_loader_pkg::kind_exe);

			// New cheat list, drop the old codes
			cheat_clear <= (kind == psx_loader_pkg::kind_code) &&
				(kind_prev != psx_loader_pkg::kind_code);
		end
	end

	// Core held in reset while its memory image is rewritten
	assign sys_reset_req = (kind == psx_loader_pkg::kind_bios) ||
		(kind == psx_loader_pkg::kind_exe);

endmodule

`default_nettype wire

// ==== rtl/halfword_gather.sv ====
// Halfword gather
// Collects host halfwords into a packed payload of any width that is a
// multiple of 32 bits and flags the payload once its last halfword lands
`default_nettype none

module halfword_gather #(
	parameter type payload_t = logic [31:0]
) (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  logic                                  en,
	input  logic                                  wr,
	input  logic [psx_loader_pkg::addr_w-1:0]     addr,
	input  logic [psx_loader_pkg::halfword_w-1:0] din,
	output logic                                  done,
	output payload_t                              payload
);

	localparam int payload_w = $bits(payload_t);
	localparam int half_cnt  = payload_w / psx_loader_pkg::halfword_w;
	localparam int word_cnt  = payload_w / psx_loader_pkg::word_w;
	localparam int sel_w     = $clog2(half_cnt);

	// Halfword position within the payload
	logic [sel_w-1:0]     half_sel;
	logic                 last_half;
	int                   lane_lsb;
	logic [payload_w-1:0] gather_q;

	// Byte address bit 0 never selects a halfword
	assign half_sel  = addr[sel_w:1];
	assign last_half = (half_sel == sel_w'(half_cnt - 1));

	// Word i/2 counted from the top, odd halfwords go to the upper half
	always_comb begin
		lane_lsb = (word_cnt - 1 - int'(half_sel >> 1)) * psx_loader_pkg::word_w;
		if (half_sel[0]) begin
			lane_lsb = lane_lsb + psx_loader_pkg::halfword_w;
		end
	end

	// ========================================
	// Payload and completion
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (en && wr) begin
			gather_q[lane_lsb +: psx_loader_pkg::halfword_w] <= din;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= en && wr && last_half;
		end
	end

	assign payload = payload_t'(gather_q);

endmodule

`default_nettype wire

// ==== rtl/psx_loader_pkg.sv ====
// Host download front end shared definitions
// File indices, region offsets and payload layouts for the loader
`default_nettype none

package psx_loader_pkg;

	// ========================================
	// Widths
	// ========================================

	// Host transfers 16-bit halfwords
	localparam int halfword_w = 16;
	// Main memory word
	localparam int word_w     = 32;
	// Byte address width of the download stream
	localparam int addr_w     = 27;

	// ========================================
	// Host file indices
	// ========================================

	localparam logic [7:0] idx_bios = 8'd0;
	localparam logic [7:0] idx_exe  = 8'd1;
	localparam logic [7:0] idx_code = 8'd255;

	// Region offsets in main memory
	localparam logic [addr_w-1:0] bios_base = 27'h0200000;
	localparam logic [addr_w-1:0] exe_base  = 27'h0400000;

	// Active download kind
	typedef enum logic [1:0] {
		kind_none = 2'd0,
		kind_bios = 2'd1,
		kind_exe  = 2'd2,
		kind_code = 2'd3
	} dl_kind_t;

	// ========================================
	// Payloads
	// ========================================

	// One memory write, byte enables are always full
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [31:0]       data;
	} mem_wr_t;

	// Cheat record, most significant word first
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// ==== rtl/psx_loader_top.sv ====
// Host download front end top level
// Connects the kind decoder, the RAM loader for BIOS and executable
// images, and the cheat record assembler
`default_nettype none

module psx_loader_top #(
	parameter int ADDR_W = 27
) (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,

	// Host download stream
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic [ADDR_W-1:0]                     ioctl_addr,
	input  logic                                  ioctl_wr,
	input  logic [psx_loader_pkg::halfword_w-1:0] ioctl_dout,
	output logic                                  ioctl_wait,

	// Main memory write port
	output logic                                  mem_req,
	output psx_loader_pkg::mem_wr_t               mem_wr,
	input  logic                                  mem_ack,

	// Core control
	output logic                                  sys_reset_req,
	output logic                                  exe_load,

	// Cheat engine
	output logic                                  cheat_clear,
	output logic                                  cheat_valid,
	output psx_loader_pkg::cheat_code_t           cheat_code
);

	psx_loader_pkg::dl_kind_t kind;
	logic                     cheat_en;

	// ========================================
	// Download kind
	// ========================================

	download_decode u_decode (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.kind          (kind),
		.sys_reset_req (sys_reset_req),
		.exe_load      (exe_load),
		.cheat_clear   (cheat_clear)
	);

	// ========================================
	// BIOS and executable images
	// ========================================

	ram_loader #(
		.ADDR_W(ADDR_W)
	) u_ram_loader (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.kind      (kind),
		.ioctl_wr  (ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.mem_ack   (mem_ack),
		.ioctl_wait(ioctl_wait),
		.mem_req   (mem_req),
		.mem_wr    (mem_wr)
	);

	// ========================================
	// Cheat records
	// ========================================

	// 16-byte records, one code per record
	assign cheat_en = (kind == psx_loader_pkg::kind_code);

	halfword_gather #(
		.payload_t(psx_loader_pkg::cheat_code_t)
	) u_cheat_gather (
		.clk_1x (clk_1x),
		.rst_n  (rst_n),
		.en     (cheat_en),
		.wr     (ioctl_wr),
		.addr   (ioctl_addr),
		.din    (ioctl_dout),
		.done   (cheat_valid),
		.payload(cheat_code)
	);

endmodule

`default_nettype wire

// ==== rtl/ram_loader.sv ====
// RAM loader for BIOS and executable downloads
// Packs halfword pairs into words, offsets them into their region and
// writes them to main memory over a four-phase req/ack port
`default_nettype none

module ram_loader #(
	parameter int ADDR_W = 27
) (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  psx_loader_pkg::dl_kind_t              kind,
	input  logic                                  ioctl_wr,
	input  logic [ADDR_W-1:0]                     ioctl_addr,
	input  logic [psx_loader_pkg::halfword_w-1:0] ioctl_dout,
	input  logic                                  mem_ack,
	output logic                                  ioctl_wait,
	output logic                                  mem_req,
	output psx_loader_pkg::mem_wr_t               mem_wr
);

	typedef logic [psx_loader_pkg::word_w-1:0] word_t;

	// Four-phase handshake
	typedef enum logic [1:0] {
		st_idle    = 2'd0,
		st_req     = 2'd1,
		st_release = 2'd2
	} hs_state_t;

	hs_state_t                         state;
	logic                              ram_en;
	logic                              word_done;
	word_t                             word;
	logic [ADDR_W-1:0]                 lo_addr;
	logic [psx_loader_pkg::addr_w-1:0] region_base;

	assign ram_en = (kind == psx_loader_pkg::kind_bios) ||
		(kind == psx_loader_pkg::kind_exe);

	assign region_base = (kind == psx_loader_pkg::kind_exe) ?
		psx_loader_pkg::exe_base : psx_loader_pkg::bios_base;

	// ========================================
	// Word assembly
	// ========================================

	halfword_gather #(
		.payload_t(word_t)
	) u_word_gather (
		.clk_1x (clk_1x),
		.rst_n  (rst_n),
		.en     (ram_en),
		.wr     (ioctl_wr),
		.addr   (ioctl_addr),
		.din    (ioctl_dout),
		.done   (word_done),
		.payload(word)
	);

	// Byte address of the low halfword is the word address
	always_ff @(posedge clk_1x) begin
		if (ram_en && ioctl_wr && !ioctl_addr[1]) begin
			lo_addr <= ioctl_addr;
		end
	end

	// ========================================
	// Memory handshake
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (word_done) begin
						state <= st_req;
					end
				end
				st_req: begin
					// Memory took the word, drop the request
					if (mem_ack) begin
						state <= st_release;
					end
				end
				st_release: begin
					// Wait for ack low before the next request
					if (!mem_ack) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Held stable for the whole request
	always_ff @(posedge clk_1x) begin
		if ((state == st_idle) && word_done) begin
			mem_wr.addr <= lo_addr + region_base;
			mem_wr.data <= word;
		end
	end

	assign mem_req = (state == st_req);

	// Host stalled until the handshake is back to idle
	assign ioctl_wait = (state != st_idle);

endmodule

`default_nettype wire

// ==== verif/loader_checker.sv ====
// Loader checker
// Watches the host stream and the DUT outputs, predicts the memory writes
// and cheat records from the halfword stream and reports each test
`default_nettype none

module loader_checker (
	input  logic                                  clk_1x,
	input  logic                                  rst_n,
	input  logic                                  ioctl_download,
	input  logic [7:0]                            ioctl_index,
	input  logic [psx_loader_pkg::addr_w-1:0]     ioctl_addr,
	input  logic                                  ioctl_wr,
	input  logic [psx_loader_pkg::halfword_w-1:0] ioctl_dout,
	input  logic                                  ioctl_wait,
	input  logic                                  mem_req,
	input  psx_loader_pkg::mem_wr_t               mem_wr,
	input  logic                                  mem_ack,
	input  logic                                  sys_reset_req,
	input  logic                                  exe_load,
	input  logic                                  cheat_clear,
	input  logic                                  cheat_valid,
	input  psx_loader_pkg::cheat_code_t           cheat_code,
	input  logic                                  test_end,
	output int                                    tests_done,
	output int                                    tests_failed,
	output int                                    error_count
);

	timeunit 1ns;
	timeprecision 1ps;

	string names [4] = '{"reset", "bios", "exe", "cheat"};

	// Host stream and DUT responses of the running test
	logic [psx_loader_pkg::addr_w-1:0]     host_addr [$];
	logic [psx_loader_pkg::halfword_w-1:0] host_data [$];
	psx_loader_pkg::mem_wr_t               got_wr [$];
	psx_loader_pkg::cheat_code_t           got_code [$];
	psx_loader_pkg::mem_wr_t               wr_q;
	logic [7:0]                            dl_index;
	logic                                  rst_seen = 1'b0;
	logic                                  req_q = 1'b0;
	logic                                  ack_q = 1'b0;
	int                                    exe_cnt = 0;
	int                                    clr_cnt = 0;
	int                                    test_errs = 0;

	initial begin
		tests_done   = 0;
		tests_failed = 0;
		error_count  = 0;
	end

	// ========================================
	// Reference model
	// ========================================

	// Low halfword goes in the lower bits
	// Address is the pair's first byte address plus the region offset
	function automatic psx_loader_pkg::mem_wr_t expected_write(int p);
		psx_loader_pkg::mem_wr_t w;
		w.addr = host_addr[2*p] + ((dl_index == psx_loader_pkg::idx_exe) ?
			psx_loader_pkg::exe_base : psx_loader_pkg::bios_base);
		w.data = {host_data[2*p+1], host_data[2*p]};
		return w;
	endfunction

	// Address bits 3:1 give the position and pairs fill the fields from the top
	function automatic psx_loader_pkg::cheat_code_t expected_code(int r);
		logic [psx_loader_pkg::halfword_w-1:0] h [8];
		logic [psx_loader_pkg::addr_w-1:0]     a;
		psx_loader_pkg::cheat_code_t           c;
		for (int k = 0; k < 8; k++) begin
			a = host_addr[8*r+k];
			h[a[3:1]] = host_data[8*r+k];
		end
		c.flags   = {h[1], h[0]};
		c.address = {h[3], h[2]};
		c.compare = {h[5], h[4]};
		c.replace = {h[7], h[6]};
		return c;
	endfunction

	task automatic check_value(string what, logic [127:0] exp_v, logic [127:0] act_v);
		if (exp_v !== act_v) begin
			$display("error %s %s: expected %0h actual %0h", names[tests_done], what,
				exp_v, act_v);
			test_errs++;
		end
	endtask

	task automatic report_problem(string what);
		$display("%s: %s", names[tests_done], what);
		test_errs++;
	endtask

	// ========================================
	// Test evaluation
	// ========================================

	task automatic evaluate_test();
		bit code_dl;
		code_dl = (dl_index == psx_loader_pkg::idx_code);
		if (tests_done == 0) begin
			check_value("mem_req", 0, mem_req);
			check_value("ioctl_wait", 0, ioctl_wait);
			check_value("cheat_valid", 0, cheat_valid);
			check_value("cheat_clear", 0, cheat_clear);
			check_value("exe_load", 0, exe_load);
			check_value("sys_reset_req", 0, sys_reset_req);
		end else begin
			check_value("sys_reset_req during download", !code_dl, rst_seen);
			check_value("sys_reset_req after download", 0, sys_reset_req);
			check_value("exe_load count", dl_index == psx_loader_pkg::idx_exe, exe_cnt);
			check_value("cheat_clear count", code_dl, clr_cnt);
			check_value("write count", code_dl ? 0 : host_data.size() / 2, got_wr.size());
			check_value("cheat_valid count", code_dl ? host_data.size() / 8 : 0,
				got_code.size());
			for (int p = 0; p < got_wr.size() && 2*p+1 < host_data.size(); p++) begin
				check_value($sformatf("write %0d", p), expected_write(p), got_wr[p]);
			end
			for (int r = 0; r < got_code.size() && 8*r+7 < host_data.size(); r++) begin
				check_value($sformatf("cheat_code %0d", r), expected_code(r), got_code[r]);
			end
		end
		$display("test %s: %s, %0d errors", names[tests_done],
			(test_errs == 0) ? "pass" : "fail", test_errs);
		if (test_errs != 0) begin
			tests_failed++;
		end
		error_count += test_errs;
		tests_done++;
		host_addr.delete();
		host_data.delete();
		got_wr.delete();
		got_code.delete();
		exe_cnt   = 0;
		clr_cnt   = 0;
		rst_seen  = 1'b0;
		test_errs = 0;
	endtask

	// ========================================
	// Monitor
	// ========================================

	always @(posedge clk_1x) begin
		if (rst_n) begin
			if (ioctl_wr && ioctl_download) begin
				dl_index = ioctl_index;
				host_addr.push_back(ioctl_addr);
				host_data.push_back(ioctl_dout);
			end
			// Four-phase port rules
			if (mem_req && !req_q) begin
				got_wr.push_back(mem_wr);
				if (ack_q) begin
					report_problem("mem_req rose while mem_ack was still high");
				end
			end
			if (mem_req && req_q && mem_wr !== wr_q) begin
				report_problem("mem_wr changed during a request");
			end
			if (mem_req && !ioctl_wait) begin
				report_problem("memory write pending while ioctl_wait was low");
			end
			if (exe_load) begin
				exe_cnt++;
				if (ioctl_download) begin
					report_problem("exe_load pulsed while ioctl_download was still high");
				end
			end
			if (cheat_clear) begin
				clr_cnt++;
				if (host_data.size() != 0) begin
					report_problem("cheat_clear came after the first halfword of the list");
				end
			end
			if (cheat_valid) begin
				got_code.push_back(cheat_code);
			end
			if (sys_reset_req && ioctl_download) begin
				rst_seen = 1'b1;
			end
			if (test_end) begin
				evaluate_test();
			end
			req_q = mem_req;
			ack_q = mem_ack;
			wr_q  = mem_wr;
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
// Testbench top for the host download front end
// Host and memory models, download sequence and run limit
`default_nettype none

module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int addr_w       = 27;
	localparam int bios_halves  = 64;
	localparam int exe_halves   = 64;
	localparam int cheat_recs   = 4;
	localparam int total_halves = bios_halves + exe_halves + 8 * cheat_recs;
	// Cycles for a host strobe plus the longest memory delay and four-phase return
	localparam int hs_worst     = 12;
	localparam int cycle_limit  = 4 * total_halves * hs_worst + 200;

	logic                                  clk_1x;
	logic                                  rst_n;
	logic                                  ioctl_download;
	logic [7:0]                            ioctl_index;
	logic [addr_w-1:0]                     ioctl_addr;
	logic                                  ioctl_wr;
	logic [psx_loader_pkg::halfword_w-1:0] ioctl_dout;
	logic                                  ioctl_wait;
	logic                                  mem_req;
	psx_loader_pkg::mem_wr_t               mem_wr;
	logic                                  mem_ack;
	logic                                  sys_reset_req;
	logic                                  exe_load;
	logic                                  cheat_clear;
	logic                                  cheat_valid;
	psx_loader_pkg::cheat_code_t           cheat_code;
	logic                                  test_end;
	int                                    tests_done;
	int                                    tests_failed;
	int                                    error_count;
	int unsigned                           delay_tab [64];
	int                                    delay_idx = 0;
	int                                    cycle_cnt = 0;

	psx_loader_top #(.ADDR_W(addr_w)) dut (.*);

	loader_checker chk (.*);

	initial begin
		clk_1x = 1'b0;
		forever begin
			#2 clk_1x = ~clk_1x;
		end
	end

	always @(posedge clk_1x) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: downloads did not complete within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// Memory acks each request after a random delay and then waits for req low
	initial begin
		forever begin
			@(posedge clk_1x);
			if (mem_req && !mem_ack) begin
				repeat (delay_tab[delay_idx]) @(posedge clk_1x);
				delay_idx = (delay_idx + 1) % 64;
				mem_ack <= 1'b1;
				do begin
					@(posedge clk_1x);
				end while (mem_req);
				mem_ack <= 1'b0;
			end
		end
	end

	// ========================================
	// Host model
	// ========================================

	task automatic send_halfword(logic [addr_w-1:0] addr,
		logic [psx_loader_pkg::halfword_w-1:0] data);
		// Two idle cycles give a finished word time to raise ioctl_wait
		repeat (2) @(posedge clk_1x);
		while (ioctl_wait) begin
			@(posedge clk_1x);
		end
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic end_test();
		test_end <= 1'b1;
		@(posedge clk_1x);
		test_end <= 1'b0;
	endtask

	task automatic run_download(logic [7:0] index, int halves);
		@(posedge clk_1x);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_1x);
		for (int i = 0; i < halves; i++) begin
			send_halfword(addr_w'(2 * i), psx_loader_pkg::halfword_w'($urandom));
		end
		// Last word written back before the host lets go
		repeat (2) @(posedge clk_1x);
		while (ioctl_wait) begin
			@(posedge clk_1x);
		end
		repeat (2) @(posedge clk_1x);
		ioctl_download <= 1'b0;
		repeat (4) @(posedge clk_1x);
		end_test();
	endtask

	// ========================================
	// Sequence
	// ========================================

	initial begin
		void'($urandom(62));
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_wr       = 1'b0;
		ioctl_dout     = '0;
		mem_ack        = 1'b0;
		test_end       = 1'b0;
		for (int i = 0; i < 64; i++) begin
			delay_tab[i] = $urandom % 7;
		end
		repeat (8) @(posedge clk_1x);
		rst_n <= 1'b1;
		@(posedge clk_1x);
		end_test();
		run_download(psx_loader_pkg::idx_bios, bios_halves);
		run_download(psx_loader_pkg::idx_exe, exe_halves);
		run_download(psx_loader_pkg::idx_code, 8 * cheat_recs);
		repeat (4) @(posedge clk_1x);
		$display("%0d tests, %0d failed, %0d errors", tests_done, tests_failed, error_count);
		if (tests_done == 4 && tests_failed == 0 && error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
